// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_cpu_top
FILELIST  := cpu_top.f
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: cpu_top.f
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_counter.sv
hdl/cpu_ctrl.sv
hdl/cpu_top.sv
tb/tb_cpu_top.sv

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    a_zero
);

	logic [3:0] shamt;

	// MIPS16 shift field, 0 stands for 8
	assign shamt = (b[2:0] == 3'd0) ? 4'd8 : {1'b0, b[2:0]};

	assign a_zero = (a == '0);  // For BEQZ / BNEZ

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_sll:    result = a << shamt;
			alu_sra:    result = word_t'($signed(a) >>> shamt);  // Keeps sign
			alu_pass_b: result = b;         // LI, MOVE
			default:    result = '0;
		endcase
	end

endmodule

// File: hdl/cpu_ctrl.sv
`timescale 1ns/100ps

module cpu_ctrl import cpu_pkg::*; (
	input  logic     pclk,
	input  logic     arst_n,
	output logic     mem_req,
	output logic     mem_we,
	output addr_t    mem_addr,
	output word_t    mem_wdata,
	input  logic     mem_ack,
	input  word_t    mem_rdata,
	input  addr_t    pc,
	output logic     pc_inc,
	output logic     pc_load,
	output addr_t    target,
	output word_t    instr,
	input  word_t    imm,
	input  logic     use_imm,
	input  logic     mem_read,
	input  logic     mem_write,
	input  logic     reg_write,
	input  br_kind_t br_kind,
	input  word_t    alu_result,
	input  logic     a_zero,
	input  word_t    rdata2,
	output word_t    alu_b,
	output logic     rf_we,
	output word_t    rf_wdata
);

	cpu_state_t state;
	word_t      ld_data;   // Load word from the bus
	logic       taken;

	//////////////////////////////////////////////////////////////////////
	// Datapath steering
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (br_kind)
			br_always: taken = 1'b1;
			br_eqz:    taken = a_zero;
			br_nez:    taken = !a_zero;
			default:   taken = 1'b0;
		endcase
	end

	assign alu_b    = use_imm ? imm : rdata2;
	assign target   = pc + imm;                              // PC already bumped
	assign pc_inc   = (state == st_fetch_wait) && mem_req && mem_ack;
	assign pc_load  = (state == st_exec) && taken;
	assign rf_we    = (state == st_write);
	assign rf_wdata = mem_read ? ld_data : alu_result;       // Load or ALU

	//////////////////////////////////////////////////////////////////////
	// FSM and bus handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_fetch_req;
			mem_req   <= 1'b0;
			mem_we    <= 1'b0;
			mem_addr  <= '0;
			mem_wdata <= '0;
		end else begin
			case (state)
				st_fetch_req: if (!mem_ack) begin
					mem_req  <= 1'b1;
					mem_we   <= 1'b0;
					mem_addr <= pc;
					state    <= st_fetch_wait;
				end
				st_fetch_wait: begin
					if (mem_req) begin
						if (mem_ack)
							mem_req <= 1'b0;       // Word captured below
					end else if (!mem_ack) begin
						state <= st_exec;        // Four-phase done
					end
				end
				st_exec: begin
					if (mem_read || mem_write)
						state <= st_mem_req;
					else if (reg_write)
						state <= st_write;
					else
						state <= st_fetch_req;   // Branch or NOP
				end
				st_mem_req: if (!mem_ack) begin
					mem_req   <= 1'b1;
					mem_we    <= mem_write;
					mem_addr  <= alu_result;     // rx + offset
					mem_wdata <= rdata2;         // ry for SW
					state     <= st_mem_wait;
				end
				st_mem_wait: begin
					if (mem_req) begin
						if (mem_ack)
							mem_req <= 1'b0;
					end else if (!mem_ack) begin
						state <= mem_read ? st_write : st_fetch_req;
					end
				end
				st_write: state <= st_fetch_req;  // rf_we high this cycle
				default:  state <= st_fetch_req;
			endcase
		end
	end

	// Instruction and load data latches
	always_ff @(posedge pclk) begin
		if (mem_req && mem_ack) begin
			if (state == st_fetch_wait)
				instr <= mem_rdata;
			else if (state == st_mem_wait && mem_read)
				ld_data <= mem_rdata;
		end
	end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] word_t;      // Data or instruction word
	typedef logic [2:0]  reg_addr_t;  // One of eight GPRs
	typedef logic [15:0] addr_t;      // Word address on the memory bus

	localparam addr_t reset_pc = 16'h0000;

	//////////////////////////////////////////////////////////////////////
	// Major opcodes, bits [15:11]
	//////////////////////////////////////////////////////////////////////

	localparam logic [4:0] op_addiu  = 5'b01001;
	localparam logic [4:0] op_addiu3 = 5'b01000;
	localparam logic [4:0] op_rr     = 5'b11100;  // ADDU / SUBU
	localparam logic [4:0] op_logic  = 5'b11101;  // AND / OR
	localparam logic [4:0] op_b      = 5'b00010;
	localparam logic [4:0] op_beqz   = 5'b00100;
	localparam logic [4:0] op_bnez   = 5'b00101;
	localparam logic [4:0] op_li     = 5'b01101;
	localparam logic [4:0] op_lw     = 5'b10011;
	localparam logic [4:0] op_sw     = 5'b11011;
	localparam logic [4:0] op_shift  = 5'b00110;  // SLL / SRA
	localparam logic [4:0] op_move   = 5'b01111;
	localparam logic [4:0] op_nop    = 5'b00001;

	// Subcodes
	localparam logic [1:0] fn_addu = 2'b01;       // opn[1:0]
	localparam logic [1:0] fn_subu = 2'b11;
	localparam logic [4:0] fn_and  = 5'b01100;    // opn[4:0]
	localparam logic [4:0] fn_or   = 5'b01101;
	localparam logic [1:0] fn_sll  = 2'b00;       // opn[1:0]
	localparam logic [1:0] fn_sra  = 2'b11;
	localparam logic [4:0] fn_move = 5'b00000;    // opn[4:0]

	//////////////////////////////////////////////////////////////////////
	// Control encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_sll, alu_sra, alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		br_none, br_always, br_eqz, br_nez
	} br_kind_t;

	typedef enum logic [2:0] {
		st_fetch_req, st_fetch_wait, st_exec, st_mem_req, st_mem_wait, st_write
	} cpu_state_t;

endpackage

// File: hdl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
	input  logic  pclk,
	input  logic  arst_n,
	output logic  mem_req,
	output logic  mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata,
	input  logic  mem_ack,
	input  word_t mem_rdata
);

	// Decode outputs
	word_t     instr, imm;
	reg_addr_t rd_addr1, rd_addr2, wr_addr;
	alu_op_t   alu_op;
	br_kind_t  br_kind;
	logic      use_imm, mem_read, mem_write, reg_write;

	// Datapath
	word_t     rdata1, rdata2, alu_b, alu_result, rf_wdata;
	logic      a_zero, rf_we;

	// PC
	addr_t     pc, target;
	logic      pc_inc, pc_load;

	cpu_ctrl u_ctrl (
		.pclk, .arst_n,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
		.pc, .pc_inc, .pc_load, .target,
		.instr, .imm, .use_imm, .mem_read, .mem_write, .reg_write, .br_kind,
		.alu_result, .a_zero, .rdata2, .alu_b,
		.rf_we, .rf_wdata
	);

	pc_counter u_pc (
		.pclk, .arst_n, .pc_inc, .pc_load, .target, .pc
	);

	decoder u_dec (
		.opn(instr),
		.read_addr1(rd_addr1), .read_addr2(rd_addr2), .reg_addr(wr_addr),
		.imm, .alu_op, .use_imm, .mem_read, .mem_write, .reg_write, .br_kind
	);

	reg_file u_rf (
		.pclk, .arst_n,
		.raddr1(rd_addr1), .raddr2(rd_addr2), .rdata1, .rdata2,
		.we(rf_we), .waddr(wr_addr), .wdata(rf_wdata)
	);

	alu u_alu (
		.op(alu_op), .a(rdata1), .b(alu_b), .result(alu_result), .a_zero
	);

endmodule

// File: hdl/decoder.sv
`timescale 1ns/100ps

module decoder import cpu_pkg::*; (
	input  word_t     opn,
	output reg_addr_t read_addr1,
	output reg_addr_t read_addr2,
	output reg_addr_t reg_addr,
	output word_t     imm,
	output alu_op_t   alu_op,
	output logic      use_imm,
	output logic      mem_read,
	output logic      mem_write,
	output logic      reg_write,
	output br_kind_t  br_kind
);

	// Immediate fields, extended
	word_t sext4, sext5, sext8, zext8, sext11, shamt;

	assign sext4  = {{12{opn[3]}}, opn[3:0]};   // ADDIU3
	assign sext5  = {{11{opn[4]}}, opn[4:0]};   // LW / SW offset
	assign sext8  = {{8{opn[7]}}, opn[7:0]};    // ADDIU, BEQZ, BNEZ
	assign zext8  = {8'h00, opn[7:0]};          // LI
	assign sext11 = {{5{opn[10]}}, opn[10:0]};  // B
	assign shamt  = {13'd0, opn[4:2]};          // SLL / SRA, 0 means 8

	always_comb begin
		// Anything not matched below falls through as a NOP
		read_addr1 = opn[10:8];
		read_addr2 = opn[7:5];
		reg_addr   = opn[10:8];
		imm        = '0;
		alu_op     = alu_add;
		use_imm    = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		reg_write  = 1'b0;
		br_kind    = br_none;

		case (opn[15:11])
			op_addiu: begin   // rx = rx + imm8
				imm       = sext8;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			op_addiu3: begin  // ry = rx + imm4
				imm       = sext4;
				use_imm   = 1'b1;
				reg_addr  = opn[7:5];
				reg_write = 1'b1;
			end
			op_rr: begin
				reg_addr = opn[4:2];  // rz
				if (opn[1:0] == fn_addu) begin
					reg_write = 1'b1;
				end else if (opn[1:0] == fn_subu) begin
					alu_op    = alu_sub;
					reg_write = 1'b1;
				end
			end
			op_logic: begin
				if (opn[4:0] == fn_and) begin
					alu_op    = alu_and;
					reg_write = 1'b1;
				end else if (opn[4:0] == fn_or) begin
					alu_op    = alu_or;
					reg_write = 1'b1;
				end
			end
			op_b: begin
				imm     = sext11;
				br_kind = br_always;
			end
			op_beqz: begin    // Tested through ALU operand A
				imm     = sext8;
				br_kind = br_eqz;
			end
			op_bnez: begin
				imm     = sext8;
				br_kind = br_nez;
			end
			op_li: begin
				imm       = zext8;
				use_imm   = 1'b1;
				alu_op    = alu_pass_b;
				reg_write = 1'b1;
			end
			op_lw: begin      // ry = mem[rx + imm5]
				imm       = sext5;
				use_imm   = 1'b1;
				reg_addr  = opn[7:5];
				mem_read  = 1'b1;
				reg_write = 1'b1;
			end
			op_sw: begin      // mem[rx + imm5] = ry
				imm       = sext5;
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			op_shift: begin
				read_addr1 = opn[7:5];  // Shifted value is ry
				imm        = shamt;
				use_imm    = 1'b1;
				if (opn[1:0] == fn_sll) begin
					alu_op    = alu_sll;
					reg_write = 1'b1;
				end else if (opn[1:0] == fn_sra) begin
					alu_op    = alu_sra;
					reg_write = 1'b1;
				end
			end
			op_move: begin
				if (opn[4:0] == fn_move) begin
					alu_op    = alu_pass_b;  // rx = ry
					reg_write = 1'b1;
				end
			end
			op_nop: begin
				// Defaults already describe it
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hdl/pc_counter.sv
`timescale 1ns/100ps

module pc_counter import cpu_pkg::*; (
	input  logic  pclk,
	input  logic  arst_n,
	input  logic  pc_inc,
	input  logic  pc_load,
	input  addr_t target,
	output addr_t pc
);

	// Next fetch address
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
		end else if (pc_load) begin
			pc <= target;      // Taken branch
		end else if (pc_inc) begin
			pc <= pc + 16'd1;  // Word addressed
		end
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
	input  logic      pclk,
	input  logic      arst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata
);

	word_t regs [0:7];

	// Async read
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;  // Single write port
		end
	end

endmodule

// File: tb/program_input.txt
// @000: program, one instruction word per line, starting at address zero
// @100: number of expected stores, then one store address and data pair per line
@000
6F80  // LI    r7, 0x80       data base
6905  // LI    r1, 5
49FE  // ADDIU r1, -2         r1 = 3
DF20  // SW    r1, 0(r7)
414C  // ADDIU3 r2, r1, -4    r2 = ffff
DF41  // SW    r2, 1(r7)
6B3C  // LI    r3, 0x3c
E331  // ADDU  r4, r3, r1     r4 = 3f
E177  // SUBU  r5, r1, r3     r5 = ffc7
DF82  // SW    r4, 2(r7)
DFA3  // SW    r5, 3(r7)
ECAC  // AND   r4, r5         r4 = 0007
EB2D  // OR    r3, r1         r3 = 3f
DF84  // SW    r4, 4(r7)
DF65  // SW    r3, 5(r7)
3660  // SLL   r6, r3, 8      shift field 0
32AF  // SRA   r2, r5, 3      r2 = fff8
DFC6  // SW    r6, 6(r7)
DF47  // SW    r2, 7(r7)
79C0  // MOVE  r1, r6
DF28  // SW    r1, 8(r7)
9F60  // LW    r3, 0(r7)      3
9F82  // LW    r4, 2(r7)      3f
E395  // ADDU  r5, r3, r4     42
DFA9  // SW    r5, 9(r7)
6903  // LI    r1, 3          loop count
6E90  // LI    r6, 0x90
DE20  // SW    r1, 0(r6)      loop top
4E01  // ADDIU r6, 1
49FF  // ADDIU r1, -1
29FC  // BNEZ  r1, -4
2201  // BEQZ  r2, +1         not taken
DE3F  // SW    r1, -1(r6)
1002  // B     +2
DFEF  // SW    skipped
DFEE  // SW    skipped
0800  // NOP
2101  // BEQZ  r1, +1         taken
DFED  // SW    skipped
6CA5  // LI    r4, 0xa5       zero extended
DF8A  // SW    r4, 10(r7)
17FF  // B     -1             park
@100
000F
0080 0003
0081 FFFF
0082 003F
0083 FFC7
0084 0007
0085 003F
0086 3F00
0087 FFF8
0088 3F00
0089 0042
0090 0003
0091 0002
0092 0001
0092 0000
008A 00A5

// File: tb/tb_cpu_top.sv
`timescale 1ns/100ps

module tb_cpu_top import cpu_pkg::*; ();

	localparam int clk_period = 4;
	localparam int max_stores = 64;

	logic  pclk;
	logic  arst_n;
	logic  mem_req;
	logic  mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	logic  mem_ack;
	word_t mem_rdata;

	word_t       image [0:511];              // Raw contents of the data file
	word_t       mem [0:255];                // Program and data share one array
	addr_t       exp_addr [0:max_stores-1];
	word_t       exp_data [0:max_stores-1];
	int          store_count;
	int          store_idx    = 0;           // Next expected store
	logic        image_loaded = 1'b0;
	logic [31:0] lcg_state    = 32'd63916;

	// Bus history, one cycle back
	logic  prev_req;
	logic  prev_ack;
	logic  prev_we;
	logic  first_req_seen;
	addr_t prev_addr;
	word_t prev_wdata;

	cpu_top DUT (
		.pclk, .arst_n,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Compares one store against the next expected pair
	task automatic check_store(input addr_t addr, input word_t data);
		assert (store_idx < store_count) else begin
			$display("A store to address %h at %0t ns came after all %0d expected stores",
				addr, $time, store_count);
			stop_with_failure();
		end
		assert (addr == exp_addr[store_idx]) else begin
			$display("Fail at %0t ns: mem_addr of store %0d expected %h, got %h",
				$time, store_idx, exp_addr[store_idx], addr);
			stop_with_failure();
		end
		assert (data == exp_data[store_idx]) else begin
			$display("Fail at %0t ns: mem_wdata of store %0d expected %h, got %h",
				$time, store_idx, exp_data[store_idx], data);
			stop_with_failure();
		end
		store_idx++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, memory model, bus checker
	//////////////////////////////////////////////////////////////////////

	initial begin : clock_gen
		pclk = 1'b0;
		forever #(clk_period / 2) pclk = ~pclk;
	end

	initial begin : memory_model
		logic [31:0] rnd;
		addr_t       req_addr;
		word_t       req_wdata;
		logic        req_we;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge pclk);
			if (arst_n && mem_req) begin
				req_addr  = mem_addr;    // Pre-edge values
				req_we    = mem_we;
				req_wdata = mem_wdata;
				rnd       = next_random();
				repeat (int'(rnd[17:16])) @(posedge pclk);  // 0 to 3 cycles
				#1;
				assert (req_addr < 16'd256) else begin
					$display("Memory access at address %h lies outside the 256-word array",
						req_addr);
					stop_with_failure();
				end
				if (req_we) begin
					mem[req_addr[7:0]] = req_wdata;
					check_store(req_addr, req_wdata);
				end else begin
					mem_rdata = mem[req_addr[7:0]];
				end
				mem_ack = 1'b1;
				@(posedge pclk);
				while (mem_req) @(posedge pclk);    // Phase 3, req dropped
				#1;
				mem_ack = 1'b0;                     // Phase 4
			end
		end
	end

	always @(posedge pclk) begin
		if (!arst_n) begin
			assert (!mem_req) else begin
				$display("Fail at %0t ns: mem_req in reset expected 0, got %b", $time, mem_req);
				stop_with_failure();
			end
			prev_req       <= 1'b0;
			prev_ack       <= 1'b0;
			first_req_seen <= 1'b0;
		end else begin
			if (mem_req && !prev_req) begin
				// Ack as seen on the edge where req went high
				assert (!prev_ack) else begin
					$display("At %0t ns mem_req rose while mem_ack was still high", $time);
					stop_with_failure();
				end
				if (!first_req_seen) begin  // First fetch after reset
					assert (mem_addr == 16'h0000) else begin
						$display("Fail at %0t ns: mem_addr expected %h, got %h",
							$time, 16'h0000, mem_addr);
						stop_with_failure();
					end
					assert (!mem_we) else begin
						$display("Fail at %0t ns: mem_we expected 0, got %b", $time, mem_we);
						stop_with_failure();
					end
					first_req_seen <= 1'b1;
				end
			end
			if (mem_req && prev_req && !prev_ack) begin  // Held until ack
				assert (mem_addr == prev_addr) else begin
					$display("Fail at %0t ns: mem_addr expected %h, got %h",
						$time, prev_addr, mem_addr);
					stop_with_failure();
				end
				assert (mem_we == prev_we) else begin
					$display("Fail at %0t ns: mem_we expected %b, got %b",
						$time, prev_we, mem_we);
					stop_with_failure();
				end
				assert (mem_wdata == prev_wdata) else begin
					$display("Fail at %0t ns: mem_wdata expected %h, got %h",
						$time, prev_wdata, mem_wdata);
					stop_with_failure();
				end
			end
			prev_req   <= mem_req;
			prev_ack   <= mem_ack;
			prev_we    <= mem_we;
			prev_addr  <= mem_addr;
			prev_wdata <= mem_wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test flow and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin : main_flow
		arst_n = 1'b0;
		for (int i = 0; i < 256; i++) begin
			image[i] = {~i[7:0], i[7:0]};  // Unwritten words stay recognizable
		end
		for (int i = 256; i < 512; i++) begin
			image[i] = '0;
		end
		$readmemh("tb/program_input.txt", image);
		for (int i = 0; i < 256; i++) begin
			mem[i] = image[i];
		end
		store_count = int'(image[256]);
		assert (store_count > 0 && store_count <= max_stores) else begin
			$display("The data file gives %0d expected stores, which is out of range",
				store_count);
			stop_with_failure();
		end
		for (int i = 0; i < store_count; i++) begin
			exp_addr[i] = image[257 + 2 * i];
			exp_data[i] = image[258 + 2 * i];
		end
		image_loaded = 1'b1;

		repeat (2) @(posedge pclk);
		#1;
		arst_n = 1'b1;

		wait (store_idx == store_count);
		repeat (50) @(posedge pclk);  // Room for a stray extra store
		$display("STATUS: PASS");
		$finish;
	end

	initial begin : watchdog
		int limit_ns;
		wait (image_loaded);
		limit_ns = (40 * store_count + 2000) * clk_period;
		#(limit_ns);
		$display("Timeout: only %0d of %0d stores arrived within %0d ns",
			store_idx, store_count, limit_ns);
		stop_with_failure();
	end

endmodule
